//--- logic/BlockCipher.sv
// ----------------------------------------------------------
// Block cipher engine
// Iterative 12-round ARX cipher, one round per clock
// ----------------------------------------------------------
`timescale 1ns/100ps

module BlockCipher
    import KeystreamPkg::*;
(
    input  logic     Clock,
    input  logic     reset,
    // Start strobe, honoured only in Idle
    input  logic     load,
    // Return to Idle once the result has been taken
    input  logic     unload,
    input  BlockType key,
    input  BlockType blockIn,
    output BlockType blockOut,
    output logic     done
);

    // ----------------------------------------------------------
    // Round function
    // ----------------------------------------------------------

    // Left rotate of one sub-word
    function automatic logic [WordWidth-1:0] rotateLeft(
        input logic [WordWidth-1:0] value,
        input int                   amount
    );
        return (value << amount) | (value >> (WordWidth - amount));
    endfunction

    // One ARX round on words w0..w3, word 0 in the low bits
    function automatic BlockType applyRound(
        input BlockType                   current,
        input BlockType                   roundKey,
        input logic [RoundIndexWidth-1:0] index
    );
        logic [WordWidth-1:0] w0;
        logic [WordWidth-1:0] w1;
        logic [WordWidth-1:0] w2;
        logic [WordWidth-1:0] w3;
        logic [WordWidth-1:0] keyWord;
        w0 = current[0*WordWidth +: WordWidth];
        w1 = current[1*WordWidth +: WordWidth];
        w2 = current[2*WordWidth +: WordWidth];
        w3 = current[3*WordWidth +: WordWidth];
        // Key word picked by round index mod 4
        keyWord = roundKey[WordWidth*(int'(index) % KeyWordCount) +: WordWidth];
        // Add, xor, rotate
        w0 = w0 + w1;
        w3 = rotateLeft(w3 ^ w0, 16);
        w2 = w2 + w3;
        w1 = rotateLeft(w1 ^ w2, 12);
        // Key and round constant mixing
        w0 = w0 ^ keyWord;
        w1 = w1 ^ WordWidth'(index);
        return {w3, w2, w1, w0};
    endfunction

    // ----------------------------------------------------------
    // State
    // ----------------------------------------------------------

    CipherState                 state;
    logic [RoundIndexWidth-1:0] roundIndex;
    // Payload, captured at load
    BlockType                   keyReg;
    BlockType                   block;

    // Control FSM
    always_ff @(posedge Clock) begin
        if (reset) begin
            state      <= Idle;
            roundIndex <= '0;
        end else begin
            case (state)
                Idle: begin
                    if (load) begin
                        state      <= Busy;
                        roundIndex <= '0;
                    end
                end
                Busy: begin
                    roundIndex <= roundIndex + 1'b1;
                    // Last round lands on the 12th edge after load
                    if (roundIndex == RoundIndexWidth'(RoundCount - 1)) begin
                        state <= Done;
                    end
                end
                Done: begin
                    if (unload) begin
                        state <= Idle;
                    end
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    // Datapath, one round per Busy cycle
    always_ff @(posedge Clock) begin
        if (state == Idle && load) begin
            keyReg <= key;
            block  <= blockIn;
        end else if (state == Busy) begin
            block <= applyRound(block, keyReg, roundIndex);
        end
    end

    // Held stable through Done
    assign blockOut = block;
    assign done     = (state == Done);

endmodule

//--- logic/KeystreamPkg.sv
// ----------------------------------------------------------
// Keystream package
// Widths, round count and engine state shared by the RTL
// ----------------------------------------------------------
package KeystreamPkg;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------

    // Input counter value
    localparam int CounterWidth = 64;

    // Key and one cipher block
    localparam int BlockWidth = 128;

    // Sub-word of a block, four per block
    localparam int WordWidth = 32;

    // Key words cycled through by the rounds
    localparam int KeyWordCount = BlockWidth / WordWidth;

    // ----------------------------------------------------------
    // Cipher schedule
    // ----------------------------------------------------------

    // One round per clock
    localparam int RoundCount = 12;

    // Enough bits to hold 0 to RoundCount-1
    localparam int RoundIndexWidth = $clog2(RoundCount);

    // Key, engine input and engine output
    typedef logic [BlockWidth-1:0] BlockType;

    // Engine state
    typedef enum logic [1:0] {
        Idle,
        Busy,
        Done
    } CipherState;

endpackage

//--- logic/KeystreamTop.sv
// ----------------------------------------------------------
// Counter-mode keystream generator
// Round-robin slots of cipher lanes on one ordered output
// ----------------------------------------------------------
`timescale 1ns/100ps

module KeystreamTop
    import KeystreamPkg::*;
#(
    parameter int SlotCount = 4,
    parameter int LaneCount = 2
) (
    input  logic                            Clock,
    input  logic                            reset,

    // ----------------------------------------------------------
    // Request side
    // ----------------------------------------------------------

    input  logic [CounterWidth-1:0]         dataIn,
    input  logic                            dataInValid,
    output logic                            dataInReady,

    input  BlockType                        key,
    input  logic                            keyValid,
    output logic                            keyReady,

    // ----------------------------------------------------------
    // Result side, no back-pressure
    // ----------------------------------------------------------

    output logic [LaneCount*BlockWidth-1:0] dataOut,
    output logic                            dataOutValid
);

    // Load strobe per slot
    logic [SlotCount-1:0]                    slotLoad;
    // Release pulse per slot
    logic [SlotCount-1:0]                    slotRelease;
    // Lane 0 done per slot
    logic [SlotCount-1:0]                    slotDone;
    // Done level of every engine
    logic [SlotCount-1:0][LaneCount-1:0]     laneDone;
    // Results, slot-major then lane
    logic [SlotCount*LaneCount*BlockWidth-1:0] slotResults;
    // Counter plus lane index, zero extended
    BlockType                                laneBlock [LaneCount];
    logic                                    outputTaken;

    // Key and data share one ready
    assign keyReady = dataInReady;

    // ----------------------------------------------------------
    // Control
    // ----------------------------------------------------------

    SlotDispatcher #(
        .SlotCount   (SlotCount)
    ) dispatcher (
        .Clock       (Clock),
        .reset       (reset),
        .dataInValid (dataInValid),
        .keyValid    (keyValid),
        .outputTaken (outputTaken),
        .dataInReady (dataInReady),
        .slotLoad    (slotLoad)
    );

    OutputArbiter #(
        .SlotCount    (SlotCount),
        .LaneCount    (LaneCount)
    ) arbiter (
        .Clock        (Clock),
        .reset        (reset),
        .slotDone     (slotDone),
        .slotResults  (slotResults),
        .dataOut      (dataOut),
        .dataOutValid (dataOutValid),
        .slotRelease  (slotRelease),
        .outputTaken  (outputTaken)
    );

    // ----------------------------------------------------------
    // Engine grid
    // ----------------------------------------------------------

    // Counter sum wraps at 64 bits before the zero extension
    for (genvar l = 0; l < LaneCount; l++) begin : laneInput
        assign laneBlock[l] = {{(BlockWidth - CounterWidth){1'b0}},
                               dataIn + CounterWidth'(l)};
    end

    for (genvar s = 0; s < SlotCount; s++) begin : slotGen
        // Lanes of one slot run in lockstep, lane 0 speaks for all
        assign slotDone[s] = laneDone[s][0];

        for (genvar l = 0; l < LaneCount; l++) begin : laneGen
            BlockCipher engine (
                .Clock    (Clock),
                .reset    (reset),
                .load     (slotLoad[s]),
                .unload   (slotRelease[s]),
                .key      (key),
                .blockIn  (laneBlock[l]),
                .blockOut (slotResults[(s*LaneCount + l)*BlockWidth +: BlockWidth]),
                .done     (laneDone[s][l])
            );
        end
    end

endmodule

//--- logic/OutputArbiter.sv
// ----------------------------------------------------------
// Output arbiter
// Hands the shared output bus to finished slots in turn
// ----------------------------------------------------------
`timescale 1ns/100ps

module OutputArbiter
    import KeystreamPkg::*;
#(
    parameter int SlotCount = 4,
    parameter int LaneCount = 2
) (
    input  logic                                   Clock,
    input  logic                                   reset,
    // Lane 0 done level of each slot
    input  logic [SlotCount-1:0]                   slotDone,
    // All lanes of all slots, slot-major
    input  logic [SlotCount*LaneCount*BlockWidth-1:0] slotResults,
    output logic [LaneCount*BlockWidth-1:0]        dataOut,
    output logic                                   dataOutValid,
    // Sends the granted slot back to Idle
    output logic [SlotCount-1:0]                   slotRelease,
    output logic                                   outputTaken
);

    localparam int TurnWidth  = $clog2(SlotCount);
    // Bits occupied by one slot on the results bus
    localparam int SlotWidth  = LaneCount * BlockWidth;

    logic [TurnWidth-1:0] outTurn;
    logic                 grant;

    // ----------------------------------------------------------
    // Grant
    // ----------------------------------------------------------

    // Only the slot at the turn may drive the bus
    assign grant = slotDone[outTurn];

    // Turn slot's lanes, valid only with grant
    assign dataOut      = slotResults[outTurn*SlotWidth +: SlotWidth];
    assign dataOutValid = grant;
    assign outputTaken  = grant;

    // Single cycle release, engine is Idle on the next edge
    assign slotRelease = grant ? (SlotCount'(1) << outTurn) : '0;

    // ----------------------------------------------------------
    // Output turn
    // ----------------------------------------------------------

    always_ff @(posedge Clock) begin
        if (reset) begin
            outTurn <= '0;
        end else if (grant) begin
            if (outTurn == TurnWidth'(SlotCount - 1)) begin
                outTurn <= '0;
            end else begin
                outTurn <= outTurn + 1'b1;
            end
        end
    end

endmodule

//--- logic/SlotDispatcher.sv
// ----------------------------------------------------------
// Slot dispatcher
// Counts occupancy, walks the input turn, issues load strobes
// ----------------------------------------------------------
`timescale 1ns/100ps

module SlotDispatcher #(
    parameter int SlotCount = 4
) (
    input  logic                 Clock,
    input  logic                 reset,
    input  logic                 dataInValid,
    input  logic                 keyValid,
    // One result left on the output bus this cycle
    input  logic                 outputTaken,
    output logic                 dataInReady,
    // One strobe per slot, shared by all lanes of that slot
    output logic [SlotCount-1:0] slotLoad
);

    // ----------------------------------------------------------
    // Local widths
    // ----------------------------------------------------------

    localparam int TurnWidth      = $clog2(SlotCount);
    // Must reach SlotCount itself
    localparam int OccupancyWidth = $clog2(SlotCount + 1);

    logic [OccupancyWidth-1:0] occupancy;
    logic [TurnWidth-1:0]      inTurn;
    logic                      accept;

    // ----------------------------------------------------------
    // Acceptance
    // ----------------------------------------------------------

    // Slots retire in order, so the turn slot is free whenever
    // fewer than SlotCount requests are outstanding
    assign dataInReady = (occupancy < OccupancyWidth'(SlotCount));

    // Needs both the counter and the key
    assign accept = dataInValid && keyValid && dataInReady;

    // Strobe the turn slot only
    always_comb begin
        slotLoad = '0;
        if (accept) begin
            slotLoad[inTurn] = 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Occupancy count
    // ----------------------------------------------------------

    always_ff @(posedge Clock) begin
        if (reset) begin
            occupancy <= '0;
        end else begin
            case ({accept, outputTaken})
                2'b10: begin
                    occupancy <= occupancy + 1'b1;
                end
                2'b01: begin
                    occupancy <= occupancy - 1'b1;
                end
                // Accept and output together cancel out
                default: begin
                    occupancy <= occupancy;
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // Input turn
    // ----------------------------------------------------------

    // Wraps at SlotCount, not at a power of two
    always_ff @(posedge Clock) begin
        if (reset) begin
            inTurn <= '0;
        end else if (accept) begin
            if (inTurn == TurnWidth'(SlotCount - 1)) begin
                inTurn <= '0;
            end else begin
                inTurn <= inTurn + 1'b1;
            end
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the keystream testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module KeystreamTb -Mdir obj_dir

output=$(./obj_dir/VKeystreamTb)
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi

//--- tb.f
logic/KeystreamPkg.sv
logic/BlockCipher.sv
logic/SlotDispatcher.sv
logic/OutputArbiter.sv
logic/KeystreamTop.sv
testbench/KeystreamTb.sv

//--- testbench/KeystreamTb.sv
// ----------------------------------------------------------
// Keystream generator testbench
// Random requests checked against a cipher model, in order
// ----------------------------------------------------------
`timescale 1ns/100ps

module KeystreamTb
    import KeystreamPkg::*;
;

    localparam int LaneCount      = 2;
    localparam int SlotCount      = 4;
    localparam int Latency        = 12;
    localparam int WaitLimit      = 100;
    localparam int WatchdogCycles = 20000;
    localparam int RandomRequests = 200;

    logic                            Clock;
    logic                            reset;
    logic [CounterWidth-1:0]         dataIn;
    logic                            dataInValid;
    logic                            dataInReady;
    BlockType                        key;
    logic                            keyValid;
    logic                            keyReady;
    logic [LaneCount*BlockWidth-1:0] dataOut;
    logic                            dataOutValid;

    // Model state
    logic [LaneCount*BlockWidth-1:0] expectedQueue [$];
    int                              acceptEdgeQueue [$];
    logic [LaneCount*BlockWidth-1:0] expectedNow;
    int                              acceptEdgeNow;
    logic [31:0]                     randomState = 32'd19883;
    int cycleCount    = 0;
    int errorCount    = 0;
    int acceptedCount = 0;
    int outputCount   = 0;
    int testsPassed   = 0;
    int testsFailed   = 0;

    KeystreamTop #(
        .SlotCount    (SlotCount),
        .LaneCount    (LaneCount)
    ) KeystreamTop_inst (
        .Clock        (Clock),
        .reset        (reset),
        .dataIn       (dataIn),
        .dataInValid  (dataInValid),
        .dataInReady  (dataInReady),
        .key          (key),
        .keyValid     (keyValid),
        .keyReady     (keyReady),
        .dataOut      (dataOut),
        .dataOutValid (dataOutValid)
    );

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    // Rising edges seen so far
    always @(posedge Clock) cycleCount <= cycleCount + 1;

    // ----------------------------------------------------------
    // Model
    // ----------------------------------------------------------

    // xorshift32
    function automatic logic [31:0] nextRandom();
        randomState = randomState ^ (randomState << 13);
        randomState = randomState ^ (randomState >> 17);
        randomState = randomState ^ (randomState << 5);
        return randomState;
    endfunction

    // Twelve ARX rounds with word 0 in the low bits
    function automatic BlockType modelCipher(input BlockType k, input BlockType plain);
        logic [31:0] w [4];
        logic [31:0] t;
        for (int i = 0; i < 4; i++) begin
            w[i] = plain[32*i +: 32];
        end
        for (int r = 0; r < RoundCount; r++) begin
            w[0] = w[0] + w[1];
            t    = w[3] ^ w[0];
            w[3] = {t[15:0], t[31:16]};
            w[2] = w[2] + w[3];
            t    = w[1] ^ w[2];
            w[1] = {t[19:0], t[31:20]};
            w[0] = w[0] ^ k[32*(r%4) +: 32];
            w[1] = w[1] ^ 32'(r);
        end
        return {w[3], w[2], w[1], w[0]};
    endfunction

    // All lanes of one request with lane j on counter plus j
    function automatic logic [LaneCount*BlockWidth-1:0] expectedResult(
        input logic [CounterWidth-1:0] counter,
        input BlockType                k
    );
        logic [LaneCount*BlockWidth-1:0] result;
        logic [CounterWidth-1:0]         laneCounter;
        for (int j = 0; j < LaneCount; j++) begin
            laneCounter = counter + CounterWidth'(j);
            result[j*BlockWidth +: BlockWidth] = modelCipher(k, {64'd0, laneCounter});
        end
        return result;
    endfunction

    // ----------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------

    task automatic checkBlock(input int lane, input BlockType expected, input BlockType actual);
        if (actual !== expected) begin
            $display("Error: dataOut lane %0d expected %h got %h", lane, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkLevel(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h got %h", name, expected, actual);
            errorCount++;
        end
    endtask

    // Output side sampled on the falling edge
    always @(negedge Clock) begin
        if (!reset && dataOutValid === 1'b1) begin
            if (expectedQueue.size() == 0) begin
                $display("Output strobe seen with no request outstanding");
                errorCount++;
            end else begin
                expectedNow   = expectedQueue.pop_front();
                acceptEdgeNow = acceptEdgeQueue.pop_front();
                for (int j = 0; j < LaneCount; j++) begin
                    checkBlock(j, expectedNow[j*BlockWidth +: BlockWidth],
                               dataOut[j*BlockWidth +: BlockWidth]);
                end
                if (cycleCount - acceptEdgeNow != Latency) begin
                    $display("Result came %0d edges after acceptance instead of %0d",
                             cycleCount - acceptEdgeNow, Latency);
                    errorCount++;
                end
            end
            outputCount++;
        end
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------

    // Starts just after a falling edge and returns one falling edge after acceptance
    task automatic sendRequest(input logic [CounterWidth-1:0] counter, input BlockType k);
        int waitCycles;
        dataIn      = counter;
        key         = k;
        dataInValid = 1'b1;
        keyValid    = 1'b1;
        waitCycles  = 0;
        while (dataInReady !== 1'b1 && waitCycles < WaitLimit) begin
            @(negedge Clock);
            waitCycles++;
        end
        if (dataInReady !== 1'b1) begin
            $display("Request was never accepted, input ready stayed low");
            errorCount++;
        end else begin
            // Taken on the coming rising edge
            expectedQueue.push_back(expectedResult(counter, k));
            acceptEdgeQueue.push_back(cycleCount + 1);
            acceptedCount++;
        end
        @(negedge Clock);
        dataInValid = 1'b0;
        keyValid    = 1'b0;
    endtask

    // Returns on the falling edge inside the next output strobe
    task automatic waitForOutput();
        int waitCycles;
        waitCycles = 0;
        while (dataOutValid !== 1'b1 && waitCycles < WaitLimit) begin
            @(negedge Clock);
            waitCycles++;
        end
        if (dataOutValid !== 1'b1) begin
            $display("No output strobe appeared while waiting for one");
            errorCount++;
        end
    endtask

    task automatic waitForDrain();
        int waitCycles;
        waitCycles = 0;
        while (expectedQueue.size() != 0 && waitCycles < WaitLimit) begin
            @(negedge Clock);
            waitCycles++;
        end
        if (expectedQueue.size() != 0) begin
            $display("Outputs still missing for %0d requests", expectedQueue.size());
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            testsPassed++;
            $display("Test %s: ok", name);
        end else begin
            testsFailed++;
            $display("Test %s: failed", name);
        end
    endtask

    // Hard stop for a stuck run
    initial begin
        for (int i = 0; i < WatchdogCycles; i++) begin
            @(posedge Clock);
        end
        $display("Simulation ran past %0d cycles without finishing", WatchdogCycles);
        $display("*** FAILED ***");
        $finish;
    end

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------

    initial begin
        int errorsBefore;
        int acceptedBefore;
        int outputsBefore;
        int gap;
        reset       = 1'b1;
        dataIn      = '0;
        dataInValid = 1'b0;
        key         = '0;
        keyValid    = 1'b0;
        repeat (2) @(negedge Clock);
        reset = 1'b0;
        @(negedge Clock);

        errorsBefore = errorCount;
        checkLevel("dataOutValid", 1'b0, dataOutValid);
        checkLevel("dataInReady", 1'b1, dataInReady);
        checkLevel("keyReady", 1'b1, keyReady);
        reportTest("reset state", errorsBefore);

        errorsBefore = errorCount;
        sendRequest(64'h0123_4567_89ab_cdef, 128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0);
        waitForDrain();
        reportTest("single request", errorsBefore);

        // Four back to back fill every slot
        errorsBefore = errorCount;
        for (int i = 0; i < SlotCount; i++) begin
            sendRequest({nextRandom(), nextRandom()},
                        {nextRandom(), nextRandom(), nextRandom(), nextRandom()});
        end
        checkLevel("dataInReady", 1'b0, dataInReady);
        checkLevel("keyReady", 1'b0, keyReady);
        // Still full while the oldest result is on the bus
        waitForOutput();
        checkLevel("dataInReady", 1'b0, dataInReady);
        // Oldest slot released on that edge
        @(negedge Clock);
        checkLevel("dataInReady", 1'b1, dataInReady);
        checkLevel("keyReady", 1'b1, keyReady);
        sendRequest(64'hffff_ffff_ffff_ffff, 128'h1);
        waitForDrain();
        reportTest("full occupancy", errorsBefore);

        // Counter offered without a key
        errorsBefore = errorCount;
        dataIn      = 64'h55;
        dataInValid = 1'b1;
        keyValid    = 1'b0;
        for (int i = 0; i < 20; i++) begin
            @(negedge Clock);
            checkLevel("dataOutValid", 1'b0, dataOutValid);
            checkLevel("dataInReady", 1'b1, dataInReady);
        end
        dataInValid = 1'b0;
        reportTest("key gating", errorsBefore);

        errorsBefore   = errorCount;
        acceptedBefore = acceptedCount;
        outputsBefore  = outputCount;
        for (int i = 0; i < RandomRequests; i++) begin
            gap = int'(nextRandom() % 4);
            for (int g = 0; g < gap; g++) begin
                @(negedge Clock);
            end
            sendRequest({nextRandom(), nextRandom()},
                        {nextRandom(), nextRandom(), nextRandom(), nextRandom()});
        end
        waitForDrain();
        if (outputCount - outputsBefore != acceptedCount - acceptedBefore) begin
            $display("Saw %0d outputs for %0d accepted requests",
                     outputCount - outputsBefore, acceptedCount - acceptedBefore);
            errorCount++;
        end
        reportTest("random stream", errorsBefore);

        $display("Tests passed %0d, failed %0d, failing checks %0d",
                 testsPassed, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
